//--- nkmd_arch_pkg.sv
package nkmd_arch_pkg;

    // ************************************************************************
    // bus widths and memory sizes
    // ************************************************************************
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int DAI_W      = 24;

    localparam int RAM_DEPTH  = 256;
    localparam int RAM_AW     = 8;                  // word index bits
    localparam int PROG_DEPTH = 256;
    localparam int PROG_AW    = 8;

    // ************************************************************************
    // address map, region in bits 15..12
    // ************************************************************************
    localparam int REG_LSB = 12;
    localparam int REG_W   = 4;

    localparam logic [REG_W-1:0] REG_RAM    = 4'd0;
    localparam logic [REG_W-1:0] REG_DAI_RX = 4'd1;
    localparam logic [REG_W-1:0] REG_DAI_TX = 4'd2;
    localparam logic [REG_W-1:0] REG_TIMER  = 4'd3;

    localparam logic [ADDR_W-1:0] ADDR_RX_DATA = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] ADDR_RX_STAT = 32'h0000_1001;
    localparam logic [ADDR_W-1:0] ADDR_TX_DATA = 32'h0000_2000;
    localparam logic [ADDR_W-1:0] ADDR_TX_STAT = 32'h0000_2001;
    localparam logic [ADDR_W-1:0] ADDR_TIMER   = 32'h0000_3000;

endpackage

//--- nkmd_isa_pkg.sv
package nkmd_isa_pkg;

    // ************************************************************************
    // instruction word: opcode in 31..24, operand in 23..0
    // ************************************************************************
    localparam int OPC_LSB = 24;
    localparam int OPND_W  = 24;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_LDI  = 8'h01,                            // acc = operand
        OP_LD   = 8'h02,                            // acc = mem[operand]
        OP_ST   = 8'h03,                            // mem[operand] = acc
        OP_ADD  = 8'h04,
        OP_SUB  = 8'h05,
        OP_JMP  = 8'h06,
        OP_JZ   = 8'h07,                            // taken when acc == 0
        OP_HALT = 8'hff
    } opcode_e;

    // ************************************************************************
    // CPU sequencing
    // ************************************************************************
    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_HALT
    } cpu_state_e;

endpackage

//--- nkmd_cpu.sv
`timescale 1ns/1ps

module nkmd_cpu (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic                              run_i,

    input  logic [nkmd_arch_pkg::DATA_W-1:0]  p_data_i,
    output logic [nkmd_arch_pkg::ADDR_W-1:0]  p_addr_o,

    input  logic [nkmd_arch_pkg::DATA_W-1:0]  r_data_i,
    output logic [nkmd_arch_pkg::ADDR_W-1:0]  r_addr_o,
    output logic [nkmd_arch_pkg::DATA_W-1:0]  r_data_o,
    output logic                              r_we_o,
    output logic                              r_re_o,

    output logic                              halt_o
);

    import nkmd_arch_pkg::*;
    import nkmd_isa_pkg::*;

    cpu_state_e         state_q;
    logic [ADDR_W-1:0]  pc_q;
    logic [DATA_W-1:0]  ir_q;
    logic [DATA_W-1:0]  acc_q;

    opcode_e            opc;
    logic [OPND_W-1:0]  opnd;
    logic               is_rd;
    logic               is_wr;

    // ************************************************************************
    // decode of the latched instruction
    // ************************************************************************
    assign opc   = opcode_e'(ir_q[DATA_W-1:OPC_LSB]);
    assign opnd  = ir_q[OPND_W-1:0];
    assign is_rd = (opc == OP_LD) || (opc == OP_ADD) || (opc == OP_SUB);
    assign is_wr = (opc == OP_ST);

    assign p_addr_o = pc_q;
    assign r_addr_o = ADDR_W'(opnd);                // zero extended
    assign r_data_o = acc_q;
    assign r_we_o   = (state_q == S_EXEC) && is_wr;
    assign r_re_o   = (state_q == S_EXEC) && is_rd;
    assign halt_o   = (state_q == S_HALT);

    // ************************************************************************
    // sequencer, pc and accumulator
    // ************************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            pc_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (run_i) begin
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state_q <= S_DECODE;                // rom sees pc this cycle
                end
                S_DECODE: begin
                    state_q <= S_EXEC;
                end
                S_EXEC: begin
                    state_q <= S_MEM;
                    pc_q    <= pc_q + 1'b1;
                    case (opc)
                        OP_JMP: begin
                            pc_q <= ADDR_W'(opnd);
                        end
                        OP_JZ: begin
                            if (acc_q == '0) begin
                                pc_q <= ADDR_W'(opnd);
                            end
                        end
                        OP_HALT: begin
                            state_q <= S_HALT;
                        end
                        default: begin
                        end
                    endcase
                end
                S_MEM: begin
                    // finish the instruction, park if run dropped
                    state_q <= run_i ? S_FETCH : S_IDLE;
                    case (opc)
                        OP_LDI: begin
                            acc_q <= DATA_W'(opnd);
                        end
                        OP_LD: begin
                            acc_q <= r_data_i;
                        end
                        OP_ADD: begin
                            acc_q <= acc_q + r_data_i;
                        end
                        OP_SUB: begin
                            acc_q <= acc_q - r_data_i;
                        end
                        default: begin
                        end
                    endcase
                end
                S_HALT: begin
                    state_q <= S_HALT;                  // only reset leaves
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_DECODE) begin
            ir_q <= p_data_i;                           // rom output of fetched pc
        end
    end

    // ************************************************************************
    // checks
    // ************************************************************************
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(r_we_o && r_re_o)
    );

    a_strobe_in_exec: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (r_we_o || r_re_o) |-> (state_q == S_EXEC) && $past(state_q == S_DECODE)
    );

endmodule

//--- nkmd_progrom_w.sv
`timescale 1ns/1ps

module nkmd_progrom_w (
    input  logic                              clk,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  addr_i,
    output logic [nkmd_arch_pkg::DATA_W-1:0]  data_o,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  prog_addr_i,
    input  logic [nkmd_arch_pkg::DATA_W-1:0]  prog_data_i,
    input  logic                              prog_ack_i
);

    import nkmd_arch_pkg::*;

    logic [DATA_W-1:0] mem [PROG_DEPTH];

    // loader port, usable at any time
    always_ff @(posedge clk) begin
        if (prog_ack_i) begin
            mem[prog_addr_i[PROG_AW-1:0]] <= prog_data_i;   // upper bits wrap
        end
    end

    always_ff @(posedge clk) begin
        data_o <= mem[addr_i[PROG_AW-1:0]];
    end

endmodule

//--- nkmd_ram.sv
`timescale 1ns/1ps

module nkmd_ram (
    input  logic                              clk,
    input  logic                              arst_n_i,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  addr_i,
    input  logic [nkmd_arch_pkg::DATA_W-1:0]  data_i,
    output logic [nkmd_arch_pkg::DATA_W-1:0]  data_o,
    input  logic                              we_i,
    input  logic                              re_i
);

    import nkmd_arch_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];
    logic [DATA_W-1:0] rd_q;
    logic              sel_q;
    logic              hit;

    assign hit = (addr_i[REG_LSB +: REG_W] == REG_RAM);

    always_ff @(posedge clk) begin
        if (we_i && hit) begin
            mem[addr_i[RAM_AW-1:0]] <= data_i;
        end
        if (re_i && hit) begin
            rd_q <= mem[addr_i[RAM_AW-1:0]];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= 1'b0;
        end else begin
            sel_q <= re_i && hit;
        end
    end

    assign data_o = sel_q ? rd_q : '0;                 // keeps the or-bus clean

endmodule

//--- nkmd_dai_rx.sv
`timescale 1ns/1ps

module nkmd_dai_rx (
    input  logic                              clk,
    input  logic                              arst_n_i,

    input  logic [nkmd_arch_pkg::DAI_W-1:0]   rx_data_i,
    input  logic                              rx_ack_i,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  addr_i,
    input  logic [nkmd_arch_pkg::DATA_W-1:0]  data_i,
    output logic [nkmd_arch_pkg::DATA_W-1:0]  data_o,
    input  logic                              we_i,
    input  logic                              re_i
);

    import nkmd_arch_pkg::*;

    logic [DAI_W-1:0] sample_q;
    logic             full_q;
    logic             sel;
    logic             rd_data;
    logic             rd_stat;
    logic             wr_stat;

    assign sel     = (addr_i[REG_LSB +: REG_W] == REG_DAI_RX);
    assign rd_data = re_i && sel && (addr_i[REG_LSB-1:0] == ADDR_RX_DATA[REG_LSB-1:0]);
    assign rd_stat = re_i && sel && (addr_i[REG_LSB-1:0] == ADDR_RX_STAT[REG_LSB-1:0]);
    assign wr_stat = we_i && sel && (addr_i[REG_LSB-1:0] == ADDR_RX_STAT[REG_LSB-1:0]);

    always_ff @(posedge clk) begin
        if (rx_ack_i) begin
            sample_q <= rx_data_i;                      // overwrites when full
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
            data_o <= '0;
        end else begin
            if (rx_ack_i) begin
                full_q <= 1'b1;                         // capture beats clear
            end else if (rd_data) begin
                full_q <= 1'b0;
            end else if (wr_stat) begin
                full_q <= data_i[0];                    // sw may drop a sample
            end

            if (rd_data) begin
                data_o <= DATA_W'(sample_q);
            end else if (rd_stat) begin
                data_o <= DATA_W'(full_q);
            end else begin
                data_o <= '0;
            end
        end
    end

    a_capture_kept: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rx_ack_i |=> full_q && (sample_q == $past(rx_data_i))
    );

endmodule

//--- nkmd_dai_tx.sv
`timescale 1ns/1ps

module nkmd_dai_tx (
    input  logic                              clk,
    input  logic                              arst_n_i,

    output logic [nkmd_arch_pkg::DAI_W-1:0]   tx_data_o,
    input  logic                              tx_pop_i,
    output logic                              tx_ack_o,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  addr_i,
    input  logic [nkmd_arch_pkg::DATA_W-1:0]  data_i,
    output logic [nkmd_arch_pkg::DATA_W-1:0]  data_o,
    input  logic                              we_i,
    input  logic                              re_i
);

    import nkmd_arch_pkg::*;

    logic [DAI_W-1:0] sample_q;
    logic             valid_q;
    logic             sel;
    logic             wr_data;
    logic             rd_data;
    logic             rd_stat;
    logic             pop_ok;

    assign sel     = (addr_i[REG_LSB +: REG_W] == REG_DAI_TX);
    assign wr_data = we_i && sel && (addr_i[REG_LSB-1:0] == ADDR_TX_DATA[REG_LSB-1:0]);
    assign rd_data = re_i && sel && (addr_i[REG_LSB-1:0] == ADDR_TX_DATA[REG_LSB-1:0]);
    assign rd_stat = re_i && sel && (addr_i[REG_LSB-1:0] == ADDR_TX_STAT[REG_LSB-1:0]);
    assign pop_ok  = tx_pop_i && valid_q;

    always_ff @(posedge clk) begin
        if (wr_data) begin
            sample_q <= data_i[DAI_W-1:0];
        end
        if (pop_ok) begin
            tx_data_o <= sample_q;                      // held after the ack
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= 1'b0;
            tx_ack_o <= 1'b0;
            data_o   <= '0;
        end else begin
            tx_ack_o <= pop_ok;
            if (wr_data) begin
                valid_q <= 1'b1;
            end else if (pop_ok) begin
                valid_q <= 1'b0;
            end

            if (rd_data) begin
                data_o <= DATA_W'(sample_q);
            end else if (rd_stat) begin
                data_o <= DATA_W'(valid_q);             // sw polls for empty
            end else begin
                data_o <= '0;
            end
        end
    end

    a_ack_single: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        tx_ack_o |=> !tx_ack_o
    );

endmodule

//--- nkmd_timer.sv
`timescale 1ns/1ps

module nkmd_timer (
    input  logic                              clk,
    input  logic                              arst_n_i,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  addr_i,
    input  logic [nkmd_arch_pkg::DATA_W-1:0]  data_i,
    output logic [nkmd_arch_pkg::DATA_W-1:0]  data_o,
    input  logic                              we_i,
    input  logic                              re_i
);

    import nkmd_arch_pkg::*;

    logic [DATA_W-1:0] count_q;
    logic              sel_q;
    logic              hit;

    assign hit = (addr_i[REG_LSB +: REG_W] == REG_TIMER)
              && (addr_i[REG_LSB-1:0] == ADDR_TIMER[REG_LSB-1:0]);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            sel_q   <= 1'b0;
        end else begin
            count_q <= (we_i && hit) ? '0 : count_q + 1'b1;    // any write clears
            sel_q   <= re_i && hit;
        end
    end

    // count as it stands in the data cycle, so strobe to strobe is measured
    assign data_o = sel_q ? count_q : '0;

endmodule

//--- nkmd_arch.sv
`timescale 1ns/1ps

module nkmd_arch (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic                              run_i,

    input  logic [nkmd_arch_pkg::DAI_W-1:0]   dai_data_i,
    input  logic                              dai_ack_i,

    output logic [nkmd_arch_pkg::DAI_W-1:0]   dai_data_o,
    input  logic                              dai_pop_i,
    output logic                              dai_ack_o,

    input  logic [nkmd_arch_pkg::ADDR_W-1:0]  prog_addr_i,
    input  logic [nkmd_arch_pkg::DATA_W-1:0]  prog_data_i,
    input  logic                              prog_ack_i,

    output logic                              halt_o
);

    import nkmd_arch_pkg::*;

    logic [DATA_W-1:0] cpu_data_i;
    logic [DATA_W-1:0] cpu_data_o;
    logic [ADDR_W-1:0] cpu_addr_o;
    logic              cpu_we_o;
    logic              cpu_re_o;

    logic [DATA_W-1:0] cpu_prog_data_i;
    logic [ADDR_W-1:0] cpu_prog_addr_o;

    logic [DATA_W-1:0] ram_data_o;
    logic [DATA_W-1:0] dai_rx_data_o;
    logic [DATA_W-1:0] dai_tx_data_o;
    logic [DATA_W-1:0] timer_data_o;

    nkmd_cpu cpu (
        .clk(clk), .arst_n_i(arst_n_i), .run_i(run_i),
        .p_data_i(cpu_prog_data_i), .p_addr_o(cpu_prog_addr_o),
        .r_data_i(cpu_data_i), .r_addr_o(cpu_addr_o), .r_data_o(cpu_data_o),
        .r_we_o(cpu_we_o), .r_re_o(cpu_re_o),
        .halt_o(halt_o)
    );

    nkmd_progrom_w rom (
        .clk(clk),
        .addr_i(cpu_prog_addr_o), .data_o(cpu_prog_data_i),
        .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i), .prog_ack_i(prog_ack_i)
    );

    nkmd_ram ram (
        .clk(clk), .arst_n_i(arst_n_i),
        .addr_i(cpu_addr_o), .data_i(cpu_data_o), .data_o(ram_data_o),
        .we_i(cpu_we_o), .re_i(cpu_re_o)
    );

    nkmd_dai_rx dai_rx (
        .clk(clk), .arst_n_i(arst_n_i),
        .rx_data_i(dai_data_i), .rx_ack_i(dai_ack_i),
        .addr_i(cpu_addr_o), .data_i(cpu_data_o), .data_o(dai_rx_data_o),
        .we_i(cpu_we_o), .re_i(cpu_re_o)
    );

    nkmd_dai_tx dai_tx (
        .clk(clk), .arst_n_i(arst_n_i),
        .tx_data_o(dai_data_o), .tx_pop_i(dai_pop_i), .tx_ack_o(dai_ack_o),
        .addr_i(cpu_addr_o), .data_i(cpu_data_o), .data_o(dai_tx_data_o),
        .we_i(cpu_we_o), .re_i(cpu_re_o)
    );

    nkmd_timer timer (
        .clk(clk), .arst_n_i(arst_n_i),
        .addr_i(cpu_addr_o), .data_i(cpu_data_o), .data_o(timer_data_o),
        .we_i(cpu_we_o), .re_i(cpu_re_o)
    );

    // idle slaves drive zero, unmapped reads come back as zero
    assign cpu_data_i = ram_data_o
                      | dai_rx_data_o
                      | dai_tx_data_o
                      | timer_data_o;

endmodule

//--- tb_nkmd_arch.sv
`timescale 1ns/1ps

module tb_nkmd_arch;

    import nkmd_arch_pkg::*;
    import nkmd_isa_pkg::*;

    localparam int          N_SAMPLES    = 8;
    localparam logic [23:0] K            = 24'h80_0321;
    localparam int          NOP_COUNT    = 5;
    localparam int          TIMER_EXPECT = 4 * (NOP_COUNT + 1);  // clear strobe to read strobe
    localparam int          PROG_LEN     = 35;
    localparam int          IDLE_POPS    = 8;
    localparam int          LOOP_INSTR   = 15;
    localparam int          CYCLE_LIMIT  = 4 + PROG_LEN + 2 * IDLE_POPS
                                         + (N_SAMPLES + 1) * LOOP_INSTR * 4 * 2 + 200;

    // ram slots used by the program
    localparam logic [23:0] RAM_K = 24'd0;
    localparam logic [23:0] RAM_CNT = 24'd1;
    localparam logic [23:0] RAM_TMP = 24'd2;
    localparam logic [23:0] RAM_ONE = 24'd3;

    localparam int T_IDLE = 0;
    localparam int T_EARLY = 1;
    localparam int T_PATH = 2;
    localparam int T_TIMER = 3;
    localparam int T_HALT = 4;

    logic              clk = 1'b0;
    logic              arst_n_i;
    logic              run_i;
    logic [DAI_W-1:0]  dai_data_i;
    logic              dai_ack_i;
    logic [DAI_W-1:0]  dai_data_o;
    logic              dai_pop_i;
    logic              dai_ack_o;
    logic [ADDR_W-1:0] prog_addr_i;
    logic [DATA_W-1:0] prog_data_i;
    logic              prog_ack_i;
    logic              halt_o;

    logic [DATA_W-1:0] prog_img [PROG_LEN];
    logic [DAI_W-1:0]  sample_tbl [N_SAMPLES];
    logic [DAI_W-1:0]  expect_tbl [N_SAMPLES];
    int                err_cnt [5];
    int                chk_cnt [5];
    string             test_name [5] = '{"idle", "early_pop", "sample_path", "timer", "halt"};
    int unsigned       cycles;

    nkmd_arch dut (
        .clk(clk), .arst_n_i(arst_n_i), .run_i(run_i),
        .dai_data_i(dai_data_i), .dai_ack_i(dai_ack_i),
        .dai_data_o(dai_data_o), .dai_pop_i(dai_pop_i), .dai_ack_o(dai_ack_o),
        .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i), .prog_ack_i(prog_ack_i),
        .halt_o(halt_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: DUT did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ************************************************************************
    // helpers
    // ************************************************************************
    function automatic logic [DATA_W-1:0] encode(input opcode_e op, input logic [23:0] opnd);
        return {op, opnd};
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;                                             // drive point after the edge
    endtask

    task automatic check_value(input int id, input string sig,
                               input logic [31:0] got, input logic [31:0] exp);
        chk_cnt[id]++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
            err_cnt[id]++;
        end
    endtask

    task automatic report_test(input int id);
        $display("test %-12s %s (%0d checks, %0d errors)", test_name[id],
                 (err_cnt[id] == 0) ? "ok" : "FAILED", chk_cnt[id], err_cnt[id]);
    endtask

    task automatic build_program();
        prog_img[0]  = encode(OP_LDI, K);
        prog_img[1]  = encode(OP_ST, RAM_K);
        prog_img[2]  = encode(OP_LDI, 24'd1);
        prog_img[3]  = encode(OP_ST, RAM_ONE);
        prog_img[4]  = encode(OP_LDI, 24'(N_SAMPLES));
        prog_img[5]  = encode(OP_ST, RAM_CNT);
        prog_img[6]  = encode(OP_LD, ADDR_RX_STAT[23:0]);   // wait for a sample
        prog_img[7]  = encode(OP_JZ, 24'd6);
        prog_img[8]  = encode(OP_LD, ADDR_RX_DATA[23:0]);
        prog_img[9]  = encode(OP_ADD, RAM_K);
        prog_img[10] = encode(OP_ST, RAM_TMP);
        prog_img[11] = encode(OP_LD, ADDR_TX_STAT[23:0]);   // wait for tx empty
        prog_img[12] = encode(OP_JZ, 24'd14);
        prog_img[13] = encode(OP_JMP, 24'd11);
        prog_img[14] = encode(OP_LD, RAM_TMP);
        prog_img[15] = encode(OP_ST, ADDR_TX_DATA[23:0]);
        prog_img[16] = encode(OP_LD, RAM_CNT);
        prog_img[17] = encode(OP_SUB, RAM_ONE);
        prog_img[18] = encode(OP_ST, RAM_CNT);
        prog_img[19] = encode(OP_JZ, 24'd21);
        prog_img[20] = encode(OP_JMP, 24'd6);
        prog_img[21] = encode(OP_ST, ADDR_TIMER[23:0]);     // clear timer
        for (int i = 0; i < NOP_COUNT; i++) begin
            prog_img[22 + i] = encode(OP_NOP, 24'd0);
        end
        prog_img[27] = encode(OP_LD, ADDR_TIMER[23:0]);
        prog_img[28] = encode(OP_ST, RAM_TMP);
        prog_img[29] = encode(OP_LD, ADDR_TX_STAT[23:0]);
        prog_img[30] = encode(OP_JZ, 24'd32);
        prog_img[31] = encode(OP_JMP, 24'd29);
        prog_img[32] = encode(OP_LD, RAM_TMP);
        prog_img[33] = encode(OP_ST, ADDR_TX_DATA[23:0]);
        prog_img[34] = encode(OP_HALT, 24'd0);
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_addr_i = ADDR_W'(i);
            prog_data_i = prog_img[i];
            prog_ack_i  = 1'b1;
            tick();
            check_value(T_IDLE, "dai_ack_o", 32'(dai_ack_o), 32'd0);
            check_value(T_IDLE, "halt_o", 32'(halt_o), 32'd0);
        end
        prog_ack_i = 1'b0;
    endtask

    task automatic send_sample(input logic [DAI_W-1:0] s);
        dai_data_i = s;
        dai_ack_i  = 1'b1;
        tick();
        dai_ack_i  = 1'b0;
    endtask

    // ack is read in the cycle after the pop
    task automatic pop_sample(output logic acked, output logic [DAI_W-1:0] data);
        dai_pop_i = 1'b1;
        tick();
        dai_pop_i = 1'b0;
        acked = dai_ack_o;
        data  = dai_data_o;
    endtask

    task automatic pop_until_ack(output logic [DAI_W-1:0] data);
        logic acked;
        int   gap;
        acked = 1'b0;
        while (!acked) begin
            gap = $urandom_range(0, 4);
            repeat (gap) tick();
            pop_sample(acked, data);
        end
    endtask

    // ************************************************************************
    // main sequence
    // ************************************************************************
    initial begin
        logic             acked;
        logic [DAI_W-1:0] data;
        int               total;

        arst_n_i    = 1'b0;
        run_i       = 1'b0;
        dai_data_i  = '0;
        dai_ack_i   = 1'b0;
        dai_pop_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        prog_ack_i  = 1'b0;
        cycles      = 0;
        total       = 0;
        for (int i = 0; i < 5; i++) begin
            err_cnt[i] = 0;
            chk_cnt[i] = 0;
        end

        void'($urandom(32'h0360a6a6));
        for (int i = 0; i < N_SAMPLES; i++) begin
            sample_tbl[i] = DAI_W'($urandom());
            expect_tbl[i] = sample_tbl[i] + K;          // wraps at 24 bits
        end
        build_program();

        repeat (4) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        load_program();
        for (int i = 0; i < IDLE_POPS; i++) begin
            pop_sample(acked, data);
            check_value(T_IDLE, "dai_ack_o", 32'(acked), 32'd0);
            check_value(T_IDLE, "halt_o", 32'(halt_o), 32'd0);
        end
        report_test(T_IDLE);

        run_i = 1'b1;
        for (int i = 0; i < N_SAMPLES; i++) begin
            send_sample(sample_tbl[i]);
            pop_sample(acked, data);                    // too early for the program
            check_value(T_EARLY, "dai_ack_o", 32'(acked), 32'd0);
            if (!acked) begin
                pop_until_ack(data);
            end
            check_value(T_PATH, "dai_data_o", 32'(data), 32'(expect_tbl[i]));
            check_value(T_HALT, "halt_o", 32'(halt_o), 32'd0);
        end
        report_test(T_EARLY);
        report_test(T_PATH);

        pop_until_ack(data);
        check_value(T_TIMER, "dai_data_o", 32'(data), 32'(TIMER_EXPECT));
        report_test(T_TIMER);

        while (halt_o !== 1'b1) begin
            tick();
        end
        for (int i = 0; i < 6; i++) begin
            pop_sample(acked, data);
            check_value(T_HALT, "dai_ack_o", 32'(acked), 32'd0);
            check_value(T_HALT, "halt_o", 32'(halt_o), 32'd1);
        end
        report_test(T_HALT);

        for (int i = 0; i < 5; i++) begin
            total += err_cnt[i];
        end
        $display("summary: 5 tests, %0d checks, %0d errors", chk_cnt.sum(), total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- nkmd_arch.f
nkmd_arch_pkg.sv
nkmd_isa_pkg.sv
nkmd_cpu.sv
nkmd_progrom_w.sv
nkmd_ram.sv
nkmd_dai_rx.sv
nkmd_dai_tx.sv
nkmd_timer.sv
nkmd_arch.sv
tb_nkmd_arch.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_nkmd_arch -f nkmd_arch.f \
    && ./obj_dir/Vtb_nkmd_arch > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with errors" sim.log 2>/dev/null && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
